/* verilog.f */
isaPkg.sv
datapathPkg.sv
instrDecoder.sv
aluExecute.sv
resultRegisters.sv
dataMemory.sv
cpuCore.sv
cpuCoreTb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - files:
      - isaPkg.sv
      - datapathPkg.sv
      - instrDecoder.sv
      - aluExecute.sv
      - resultRegisters.sv
      - dataMemory.sv
      - cpuCore.sv
  - target: simulation
    files:
      - cpuCoreTb.sv

/* cpuCoreTb.sv */
module cpuCoreTb;

    localparam int Width = datapathPkg::DefaultDataWidth;
    localparam int Depth = datapathPkg::DefaultMemDepth;
    localparam int AddrBits = $clog2(Depth);
    localparam int NumInstr = 2000;
    // Four cycles per three instructions on average, plus reset and margin
    localparam int MaxCycles = 3000;

    typedef logic [Width-1:0] wordT;

    logic                clk;
    logic                arstN;
    logic                instrValid;
    isaPkg::opcodeT      opcode;
    wordT                literal;
    wordT                regA;
    wordT                regB;
    datapathPkg::statusT status;
    wordT                pc;

    // Reference model state
    wordT                mA;
    wordT                mB;
    wordT                mPc;
    datapathPkg::statusT mStatus;
    wordT                mMem [Depth];

    integer              seed;
    int                  errors;
    int                  checks;
    int                  cycles;
    int                  issued;
    isaPkg::opcodeT      keptOps [$];

    cpuCore DUT
    (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .opcode     (opcode),
        .literal    (literal),
        .regA       (regA),
        .regB       (regB),
        .status     (status),
        .pc         (pc)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        cycles = 0;
        forever
        begin
            @(posedge clk);
            cycles++;
            if (cycles >= MaxCycles)
            begin
                $display("Timeout after %0d cycles, only %0d instructions issued",
                         cycles, issued);
                $display("Checks: %0d, errors: %0d", checks, errors);
                $display("*** TEST FAILED ***");
                $finish;
            end
        end
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    task automatic aluRef(input isaPkg::aluOpE kind, input wordT x, input wordT y,
                          output wordT res, output datapathPkg::statusT flags);
        int  sx;
        int  sy;
        int  sres;
        logic c;
        logic v;
        sx = $signed(x);
        sy = $signed(y);
        c = 1'b0;
        v = 1'b0;
        case (kind)
            isaPkg::AluAdd:
            begin
                res = x + y;
                c = (int'(x) + int'(y)) >= (1 << Width);
                sres = sx + sy;
                v = (sres >= (1 << (Width - 1))) || (sres < -(1 << (Width - 1)));
            end
            isaPkg::AluSub:
            begin
                res = x - y;
                c = (x < y);
                sres = sx - sy;
                v = (sres >= (1 << (Width - 1))) || (sres < -(1 << (Width - 1)));
            end
            isaPkg::AluAnd: res = x & y;
            isaPkg::AluOr:  res = x | y;
            isaPkg::AluXor: res = x ^ y;
            isaPkg::AluNot: res = ~x;
            isaPkg::AluShl:
            begin
                res = x << 1;
                c = x[Width-1];
            end
            default:
            begin
                res = x >> 1;
                c = x[0];
            end
        endcase
        flags[datapathPkg::StatusZero] = (res == '0);
        flags[datapathPkg::StatusNeg] = res[Width-1];
        flags[datapathPkg::StatusCarry] = c;
        flags[datapathPkg::StatusOvf] = v;
    endtask

    function automatic logic jumpTaken(input isaPkg::opcodeT op,
                                       input datapathPkg::statusT st);
        logic z;
        logic n;
        z = st[datapathPkg::StatusZero];
        n = st[datapathPkg::StatusNeg];
        case (op)
            isaPkg::OpJmp: return 1'b1;
            isaPkg::OpJeq: return z;
            isaPkg::OpJne: return !z;
            isaPkg::OpJgt: return !z && !n;
            isaPkg::OpJlt: return n;
            isaPkg::OpJge: return !n;
            isaPkg::OpJle: return n || z;
            isaPkg::OpJcr: return st[datapathPkg::StatusCarry];
            isaPkg::OpJov: return st[datapathPkg::StatusOvf];
            default:       return 1'b0;
        endcase
    endfunction

    task automatic applyInstr(input isaPkg::opcodeT op, input wordT lit);
        isaPkg::aluOpE       kind;
        wordT                x;
        wordT                y;
        wordT                res;
        datapathPkg::statusT flags;
        logic                toA;
        logic                toB;
        logic                useAlu;
        logic                taken;
        taken = jumpTaken(op, mStatus);
        kind = isaPkg::AluAdd;
        x = mA;
        y = mB;
        toA = 1'b0;
        toB = 1'b0;
        useAlu = 1'b1;
        // Operation family
        case (op)
            isaPkg::OpAddAB, isaPkg::OpAddBA, isaPkg::OpAddALit, isaPkg::OpAddBLit:
                kind = isaPkg::AluAdd;
            isaPkg::OpSubAB, isaPkg::OpSubBA, isaPkg::OpSubALit, isaPkg::OpSubBLit,
            isaPkg::OpCmpAB, isaPkg::OpCmpALit:
                kind = isaPkg::AluSub;
            isaPkg::OpAndAB, isaPkg::OpAndBA, isaPkg::OpAndALit, isaPkg::OpAndBLit:
                kind = isaPkg::AluAnd;
            isaPkg::OpOrAB, isaPkg::OpOrBA, isaPkg::OpOrALit, isaPkg::OpOrBLit:
                kind = isaPkg::AluOr;
            isaPkg::OpXorAB, isaPkg::OpXorBA, isaPkg::OpXorALit, isaPkg::OpXorBLit:
                kind = isaPkg::AluXor;
            isaPkg::OpNotA, isaPkg::OpNotB: kind = isaPkg::AluNot;
            isaPkg::OpShlA, isaPkg::OpShlB: kind = isaPkg::AluShl;
            isaPkg::OpShrA, isaPkg::OpShrB: kind = isaPkg::AluShr;
            default: useAlu = 1'b0;
        endcase
        // Operand form and destination
        case (op)
            isaPkg::OpAddAB, isaPkg::OpSubAB, isaPkg::OpAndAB, isaPkg::OpOrAB,
            isaPkg::OpXorAB, isaPkg::OpNotA, isaPkg::OpShlA, isaPkg::OpShrA:
                toA = 1'b1;
            isaPkg::OpAddBA, isaPkg::OpSubBA, isaPkg::OpAndBA, isaPkg::OpOrBA,
            isaPkg::OpXorBA:
                toB = 1'b1;
            isaPkg::OpAddALit, isaPkg::OpSubALit, isaPkg::OpAndALit, isaPkg::OpOrALit,
            isaPkg::OpXorALit:
            begin
                y = lit;
                toA = 1'b1;
            end
            isaPkg::OpAddBLit, isaPkg::OpSubBLit, isaPkg::OpAndBLit, isaPkg::OpOrBLit,
            isaPkg::OpXorBLit:
            begin
                x = mB;
                y = lit;
                toB = 1'b1;
            end
            isaPkg::OpNotB, isaPkg::OpShlB, isaPkg::OpShrB:
            begin
                x = mB;
                toB = 1'b1;
            end
            isaPkg::OpCmpALit: y = lit;
            default:
            begin
            end
        endcase
        if (useAlu)
        begin
            aluRef(kind, x, y, res, flags);
            if (toA)
                mA = res;
            if (toB)
                mB = res;
            mStatus = flags;
        end
        // Moves and memory leave the status alone
        case (op)
            isaPkg::OpMovAB:   mA = mB;
            isaPkg::OpMovBA:   mB = mA;
            isaPkg::OpMovALit: mA = lit;
            isaPkg::OpMovBLit: mB = lit;
            isaPkg::OpLdA:     mA = mMem[lit[AddrBits-1:0]];
            isaPkg::OpLdB:     mB = mMem[lit[AddrBits-1:0]];
            isaPkg::OpStA:     mMem[lit[AddrBits-1:0]] = mA;
            isaPkg::OpStB:     mMem[lit[AddrBits-1:0]] = mB;
            default:
            begin
            end
        endcase
        mPc = taken ? lit : mPc + wordT'(1);
    endtask

    ////////////////////////////////////////
    // Stimulus and checks
    ////////////////////////////////////////

    task automatic buildOpTable();
        isaPkg::opcodeE e;
        e = e.first();
        do
        begin
            keptOps.push_back(e);
            e = e.next();
        end
        while (e != e.first());
    endtask

    // Mostly kept opcodes, sometimes any 7-bit value
    function automatic isaPkg::opcodeT pickOpcode();
        if (($random(seed) & 15) == 0)
            return isaPkg::opcodeT'($random(seed));
        return keptOps[$unsigned($random(seed)) % keptOps.size()];
    endfunction

    task automatic checkState();
        checks++;
        if (regA !== mA)
        begin
            errors++;
            $display("MISMATCH regA: got %h, expected %h", regA, mA);
        end
        if (regB !== mB)
        begin
            errors++;
            $display("MISMATCH regB: got %h, expected %h", regB, mB);
        end
        if (status !== mStatus)
        begin
            errors++;
            $display("MISMATCH status: got %h, expected %h", status, mStatus);
        end
        if (pc !== mPc)
        begin
            errors++;
            $display("MISMATCH pc: got %h, expected %h", pc, mPc);
        end
    endtask

    initial
    begin
        seed = 32'hf432baff;
        errors = 0;
        checks = 0;
        issued = 0;
        arstN = 1'b0;
        instrValid = 1'b0;
        opcode = '0;
        literal = '0;
        mA = '0;
        mB = '0;
        mPc = '0;
        mStatus = '0;
        for (int i = 0; i < Depth; i++)
            mMem[i] = '0;
        buildOpTable();

        repeat (5) @(posedge clk);
        #10;
        arstN = 1'b1;
        checkState();

        // A few idle cycles first
        repeat (3)
        begin
            @(posedge clk);
            #10;
            checkState();
        end

        while (issued < NumInstr)
        begin
            instrValid = ($random(seed) & 3) != 0;
            opcode = pickOpcode();
            literal = wordT'($random(seed));
            if (instrValid)
            begin
                applyInstr(opcode, literal);
                issued++;
            end
            @(posedge clk);
            #10;
            checkState();
        end
        instrValid = 1'b0;

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* cpuCore.sv */
module cpuCore
#(
    parameter int DataWidth = datapathPkg::DefaultDataWidth,
    parameter int MemDepth = datapathPkg::DefaultMemDepth
)
(
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 instrValid,
    input  isaPkg::opcodeT       opcode,
    input  logic [DataWidth-1:0] literal,
    output logic [DataWidth-1:0] regA,
    output logic [DataWidth-1:0] regB,
    output datapathPkg::statusT  status,
    output logic [DataWidth-1:0] pc
);

    logic                 loadA;
    logic                 loadB;
    logic                 loadStatus;
    logic                 memWrite;
    logic                 pcLoad;
    isaPkg::aluOpE        aluOp;
    isaPkg::operandASelE  operandASel;
    isaPkg::operandBSelE  operandBSel;
    isaPkg::storeSelE     storeSel;
    logic [DataWidth-1:0] result;
    logic [DataWidth-1:0] memData;
    datapathPkg::statusT  flagsNext;

    ////////////////////////////////////////
    // Decode and execute
    ////////////////////////////////////////

    instrDecoder uDecoder
    (
        .opcode      (opcode),
        .status      (status),
        .loadA       (loadA),
        .loadB       (loadB),
        .loadStatus  (loadStatus),
        .memWrite    (memWrite),
        .pcLoad      (pcLoad),
        .aluOp       (aluOp),
        .operandASel (operandASel),
        .operandBSel (operandBSel),
        .storeSel    (storeSel)
    );

    aluExecute #(
        .DataWidth (DataWidth)
    ) uExecute (
        .regA        (regA),
        .regB        (regB),
        .literal     (literal),
        .memData     (memData),
        .operandASel (operandASel),
        .operandBSel (operandBSel),
        .aluOp       (aluOp),
        .result      (result),
        .flagsNext   (flagsNext)
    );

    ////////////////////////////////////////
    // State
    ////////////////////////////////////////

    resultRegisters #(
        .DataWidth (DataWidth)
    ) uResult (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .loadA      (loadA),
        .loadB      (loadB),
        .loadStatus (loadStatus),
        .pcLoad     (pcLoad),
        .result     (result),
        .literal    (literal),
        .flagsNext  (flagsNext),
        .regA       (regA),
        .regB       (regB),
        .status     (status),
        .pc         (pc)
    );

    dataMemory #(
        .DataWidth (DataWidth),
        .MemDepth  (MemDepth)
    ) uMemory (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .memWrite   (memWrite),
        .storeSel   (storeSel),
        .regA       (regA),
        .regB       (regB),
        .literal    (literal),
        .memData    (memData)
    );

endmodule

/* dataMemory.sv */
module dataMemory
#(
    parameter int DataWidth = 8,
    parameter int MemDepth = 16
)
(
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 instrValid,
    input  logic                 memWrite,
    input  isaPkg::storeSelE     storeSel,
    input  logic [DataWidth-1:0] regA,
    input  logic [DataWidth-1:0] regB,
    input  logic [DataWidth-1:0] literal,
    output logic [DataWidth-1:0] memData
);

    localparam int AddrWidth = $clog2(MemDepth);

    logic [DataWidth-1:0] memArray [MemDepth];
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] writeData;

    // Low literal bits only
    assign addr = literal[AddrWidth-1:0];
    assign writeData = (storeSel == isaPkg::StoreB) ? regB : regA;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < MemDepth; i++)
                memArray[i] <= '0;
        end
        else if (instrValid && memWrite)
            memArray[addr] <= writeData;
    end

    assign memData = memArray[addr];

    // Idle cycle leaves the addressed word alone
    assert property (@(posedge clk) disable iff (!arstN)
        !instrValid |=> memArray[$past(addr)] == $past(memData))
        else $error("memory changed without instrValid");

endmodule

/* resultRegisters.sv */
module resultRegisters
#(
    parameter int DataWidth = 8
)
(
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 instrValid,
    input  logic                 loadA,
    input  logic                 loadB,
    input  logic                 loadStatus,
    input  logic                 pcLoad,
    input  logic [DataWidth-1:0] result,
    input  logic [DataWidth-1:0] literal,
    input  datapathPkg::statusT  flagsNext,
    output logic [DataWidth-1:0] regA,
    output logic [DataWidth-1:0] regB,
    output datapathPkg::statusT  status,
    output logic [DataWidth-1:0] pc
);

    ////////////////////////////////////////
    // Register file and status
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            regA <= '0;
            regB <= '0;
            status <= '0;
        end
        else if (instrValid)
        begin
            if (loadA)
                regA <= result;
            if (loadB)
                regB <= result;
            if (loadStatus)
                status <= flagsNext;
        end
    end

    // Jump target or next instruction
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            pc <= '0;
        else if (instrValid)
            pc <= pcLoad ? literal : pc + DataWidth'(1);
    end

endmodule

/* aluExecute.sv */
module aluExecute
#(
    parameter int DataWidth = 8
)
(
    input  logic [DataWidth-1:0] regA,
    input  logic [DataWidth-1:0] regB,
    input  logic [DataWidth-1:0] literal,
    input  logic [DataWidth-1:0] memData,
    input  isaPkg::operandASelE  operandASel,
    input  isaPkg::operandBSelE  operandBSel,
    input  isaPkg::aluOpE        aluOp,
    output logic [DataWidth-1:0] result,
    output datapathPkg::statusT  flagsNext
);

    localparam int Msb = DataWidth - 1;

    logic [DataWidth-1:0] opA;
    logic [DataWidth-1:0] opB;
    logic [DataWidth:0]   sumWide;
    logic                 carry;
    logic                 ovf;

    ////////////////////////////////////////
    // Operand muxes
    ////////////////////////////////////////

    always_comb
    begin
        case (operandASel)
            isaPkg::ASelA: opA = regA;
            isaPkg::ASelB: opA = regB;
            default:       opA = '0;
        endcase
    end

    always_comb
    begin
        case (operandBSel)
            isaPkg::BSelB:   opB = regB;
            isaPkg::BSelLit: opB = literal;
            isaPkg::BSelMem: opB = memData;
            default:         opB = '0;
        endcase
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb
    begin
        sumWide = '0;
        carry = 1'b0;
        ovf = 1'b0;
        case (aluOp)
            isaPkg::AluAdd:
            begin
                sumWide = {1'b0, opA} + {1'b0, opB};
                result = sumWide[Msb:0];
                carry = sumWide[DataWidth];
                ovf = (opA[Msb] == opB[Msb]) && (result[Msb] != opA[Msb]);
            end
            isaPkg::AluSub:
            begin
                // Top bit is the borrow, set when opA < opB unsigned
                sumWide = {1'b0, opA} - {1'b0, opB};
                result = sumWide[Msb:0];
                carry = sumWide[DataWidth];
                ovf = (opA[Msb] != opB[Msb]) && (result[Msb] != opA[Msb]);
            end
            isaPkg::AluAnd: result = opA & opB;
            isaPkg::AluOr:  result = opA | opB;
            isaPkg::AluNot: result = ~opA;
            isaPkg::AluXor: result = opA ^ opB;
            isaPkg::AluShl:
            begin
                result = {opA[Msb-1:0], 1'b0};
                carry = opA[Msb];
            end
            default:
            begin
                result = {1'b0, opA[Msb:1]};
                carry = opA[0];
            end
        endcase
    end

    assign flagsNext[datapathPkg::StatusZero] = (result == '0);
    assign flagsNext[datapathPkg::StatusNeg] = result[Msb];
    assign flagsNext[datapathPkg::StatusCarry] = carry;
    assign flagsNext[datapathPkg::StatusOvf] = ovf;

    // Logic ops never report carry or overflow
    always_comb
    begin
        if (aluOp inside {isaPkg::AluAnd, isaPkg::AluOr, isaPkg::AluNot, isaPkg::AluXor})
        begin
            assert final (!flagsNext[datapathPkg::StatusCarry] &&
                          !flagsNext[datapathPkg::StatusOvf])
                else $error("carry or overflow after a logic op");
        end
    end

endmodule

/* instrDecoder.sv */
module instrDecoder
(
    input  isaPkg::opcodeT      opcode,
    input  datapathPkg::statusT status,
    output logic                loadA,
    output logic                loadB,
    output logic                loadStatus,
    output logic                memWrite,
    output logic                pcLoad,
    output isaPkg::aluOpE       aluOp,
    output isaPkg::operandASelE operandASel,
    output isaPkg::operandBSelE operandBSel,
    output isaPkg::storeSelE    storeSel
);

    isaPkg::opcodeE op;
    logic           flagZ;
    logic           flagN;
    logic           flagC;
    logic           flagV;

    assign op = isaPkg::opcodeE'(opcode);

    assign flagZ = status[datapathPkg::StatusZero];
    assign flagN = status[datapathPkg::StatusNeg];
    assign flagC = status[datapathPkg::StatusCarry];
    assign flagV = status[datapathPkg::StatusOvf];

    ////////////////////////////////////////
    // ALU operation per instruction family
    ////////////////////////////////////////

    always_comb
    begin
        case (op)
            isaPkg::OpSubAB, isaPkg::OpSubBA, isaPkg::OpSubALit, isaPkg::OpSubBLit,
            isaPkg::OpCmpAB, isaPkg::OpCmpALit:
                aluOp = isaPkg::AluSub;
            isaPkg::OpAndAB, isaPkg::OpAndBA, isaPkg::OpAndALit, isaPkg::OpAndBLit:
                aluOp = isaPkg::AluAnd;
            isaPkg::OpOrAB, isaPkg::OpOrBA, isaPkg::OpOrALit, isaPkg::OpOrBLit:
                aluOp = isaPkg::AluOr;
            isaPkg::OpXorAB, isaPkg::OpXorBA, isaPkg::OpXorALit, isaPkg::OpXorBLit:
                aluOp = isaPkg::AluXor;
            isaPkg::OpNotA, isaPkg::OpNotB:
                aluOp = isaPkg::AluNot;
            isaPkg::OpShlA, isaPkg::OpShlB:
                aluOp = isaPkg::AluShl;
            isaPkg::OpShrA, isaPkg::OpShrB:
                aluOp = isaPkg::AluShr;
            // MOV and loads pass through the adder with a zero operand
            default:
                aluOp = isaPkg::AluAdd;
        endcase
    end

    ////////////////////////////////////////
    // Operand form and destination
    ////////////////////////////////////////

    always_comb
    begin
        loadA = 1'b0;
        loadB = 1'b0;
        loadStatus = 1'b0;
        memWrite = 1'b0;
        pcLoad = 1'b0;
        operandASel = isaPkg::ASelZero;
        operandBSel = isaPkg::BSelZero;
        storeSel = isaPkg::StoreA;

        case (op)
            isaPkg::OpMovAB:
            begin
                loadA = 1'b1;
                operandBSel = isaPkg::BSelB;
            end
            isaPkg::OpMovBA:
            begin
                loadB = 1'b1;
                operandASel = isaPkg::ASelA;
            end
            isaPkg::OpMovALit, isaPkg::OpMovBLit:
            begin
                loadA = (op == isaPkg::OpMovALit);
                loadB = (op == isaPkg::OpMovBLit);
                operandBSel = isaPkg::BSelLit;
            end
            isaPkg::OpAddAB, isaPkg::OpSubAB, isaPkg::OpAndAB, isaPkg::OpOrAB,
            isaPkg::OpXorAB:
            begin
                loadA = 1'b1;
                loadStatus = 1'b1;
                operandASel = isaPkg::ASelA;
                operandBSel = isaPkg::BSelB;
            end
            isaPkg::OpAddBA, isaPkg::OpSubBA, isaPkg::OpAndBA, isaPkg::OpOrBA,
            isaPkg::OpXorBA:
            begin
                loadB = 1'b1;
                loadStatus = 1'b1;
                operandASel = isaPkg::ASelA;
                operandBSel = isaPkg::BSelB;
            end
            isaPkg::OpAddALit, isaPkg::OpSubALit, isaPkg::OpAndALit, isaPkg::OpOrALit,
            isaPkg::OpXorALit:
            begin
                loadA = 1'b1;
                loadStatus = 1'b1;
                operandASel = isaPkg::ASelA;
                operandBSel = isaPkg::BSelLit;
            end
            isaPkg::OpAddBLit, isaPkg::OpSubBLit, isaPkg::OpAndBLit, isaPkg::OpOrBLit,
            isaPkg::OpXorBLit:
            begin
                loadB = 1'b1;
                loadStatus = 1'b1;
                operandASel = isaPkg::ASelB;
                operandBSel = isaPkg::BSelLit;
            end
            // Unary forms work on the destination itself
            isaPkg::OpNotA, isaPkg::OpShlA, isaPkg::OpShrA:
            begin
                loadA = 1'b1;
                loadStatus = 1'b1;
                operandASel = isaPkg::ASelA;
            end
            isaPkg::OpNotB, isaPkg::OpShlB, isaPkg::OpShrB:
            begin
                loadB = 1'b1;
                loadStatus = 1'b1;
                operandASel = isaPkg::ASelB;
            end
            isaPkg::OpCmpAB, isaPkg::OpCmpALit:
            begin
                loadStatus = 1'b1;
                operandASel = isaPkg::ASelA;
                operandBSel = (op == isaPkg::OpCmpAB) ? isaPkg::BSelB : isaPkg::BSelLit;
            end
            isaPkg::OpLdA, isaPkg::OpLdB:
            begin
                loadA = (op == isaPkg::OpLdA);
                loadB = (op == isaPkg::OpLdB);
                operandBSel = isaPkg::BSelMem;
            end
            isaPkg::OpStA, isaPkg::OpStB:
            begin
                memWrite = 1'b1;
                storeSel = (op == isaPkg::OpStB) ? isaPkg::StoreB : isaPkg::StoreA;
            end
            // Branch conditions on the current status
            isaPkg::OpJmp: pcLoad = 1'b1;
            isaPkg::OpJeq: pcLoad = flagZ;
            isaPkg::OpJne: pcLoad = !flagZ;
            isaPkg::OpJgt: pcLoad = !flagZ && !flagN;
            isaPkg::OpJlt: pcLoad = flagN;
            isaPkg::OpJge: pcLoad = !flagN;
            isaPkg::OpJle: pcLoad = flagN || flagZ;
            isaPkg::OpJcr: pcLoad = flagC;
            isaPkg::OpJov: pcLoad = flagV;
            default:
            begin
                // Unknown opcode, pc still advances
            end
        endcase
    end

    // One destination per instruction
    always_comb
    begin
        assert final (!(memWrite && (loadA || loadB)))
            else $error("memory write together with a register load");
        assert final (!(loadA && loadB))
            else $error("loadA and loadB both set");
    end

endmodule

/* datapathPkg.sv */
package datapathPkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int DefaultDataWidth = 8;

    // Words, addressed by the low literal bits
    localparam int DefaultMemDepth = 16;

    ////////////////////////////////////////
    // Status register
    ////////////////////////////////////////

    typedef logic [3:0] statusT;

    localparam int StatusZero = 3;
    localparam int StatusNeg = 2;
    localparam int StatusCarry = 1;
    localparam int StatusOvf = 0;

endpackage

/* isaPkg.sv */
package isaPkg;

    ////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////

    typedef logic [6:0] opcodeT;

    // Gaps in the numbering belong to the dropped memory and indirect forms
    typedef enum opcodeT {
        OpMovAB   = 7'd0,
        OpMovBA   = 7'd1,
        OpMovALit = 7'd2,
        OpMovBLit = 7'd3,
        OpAddAB   = 7'd4,  OpAddBA   = 7'd5,  OpAddALit = 7'd6,  OpAddBLit = 7'd7,
        OpSubAB   = 7'd8,  OpSubBA   = 7'd9,  OpSubALit = 7'd10, OpSubBLit = 7'd11,
        OpAndAB   = 7'd12, OpAndBA   = 7'd13, OpAndALit = 7'd14, OpAndBLit = 7'd15,
        OpOrAB    = 7'd16, OpOrBA    = 7'd17, OpOrALit  = 7'd18, OpOrBLit  = 7'd19,
        OpNotA    = 7'd20,
        OpNotB    = 7'd23,
        OpXorAB   = 7'd24, OpXorBA   = 7'd25, OpXorALit = 7'd26, OpXorBLit = 7'd27,
        OpShlA    = 7'd28,
        OpShlB    = 7'd31,
        OpShrA    = 7'd32,
        OpShrB    = 7'd35,
        // Direct addressing only
        OpLdA     = 7'd37,
        OpLdB     = 7'd38,
        OpStA     = 7'd39,
        OpStB     = 7'd40,
        OpCmpAB   = 7'd77,
        OpCmpALit = 7'd78,
        OpJmp     = 7'd83,
        OpJeq     = 7'd84,
        OpJne     = 7'd85,
        OpJgt     = 7'd86,
        OpJlt     = 7'd87,
        OpJge     = 7'd88,
        OpJle     = 7'd89,
        OpJcr     = 7'd90,
        OpJov     = 7'd91
    } opcodeE;

    ////////////////////////////////////////
    // Datapath controls
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        AluAdd = 3'd0,
        AluSub = 3'd1,
        AluAnd = 3'd2,
        AluOr  = 3'd3,
        AluNot = 3'd4,
        AluXor = 3'd5,
        AluShl = 3'd6,
        AluShr = 3'd7
    } aluOpE;

    // Code 01 was the increment path
    typedef enum logic [1:0] {
        ASelA    = 2'b00,
        ASelZero = 2'b10,
        ASelB    = 2'b11
    } operandASelE;

    typedef enum logic [1:0] {
        BSelB    = 2'b00,
        BSelLit  = 2'b01,
        BSelZero = 2'b10,
        BSelMem  = 2'b11
    } operandBSelE;

    typedef enum logic {
        StoreA = 1'b0,
        StoreB = 1'b1
    } storeSelE;

endpackage
